// File: Makefile
# Verilator build and run of the execute lane testbench.
# Any variable below can be overridden, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= simple_lane_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
+incdir+source
source/isa_pkg.sv
source/lane_pkg.sv
source/simple_alu.sv
source/exec_regfile.sv
source/operand_bypass.sv
source/exec_ctrl.sv
source/simple_lane_top.sv
test/simple_lane_tb.sv

// File: source/exec_cfg.svh
// Sizing of the execute lane, shared by both packages and the RTL.
// NUM_PHYS_REGS must equal 2**SIZE_PHYS_LOG, and shift amounts assume SIZE_DATA is 32.
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath widths.
`define SIZE_DATA        32
`define SIZE_IMMEDIATE   16
`define SIZE_OPCODE_I    6

// Six status bits per completed instruction.
`define EXECUTION_FLAGS  6

// Physical register file size and tag width.
`define NUM_PHYS_REGS    16
`define SIZE_PHYS_LOG    4

`endif

// File: source/exec_ctrl.sv
// Valid-bit control for the R, X and W stages of the lane.
// No stall or flush, so every issued instruction completes two cycles later.

module exec_ctrl (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               issue_valid_i,
    input  lane_pkg::preg_t    src1_i,
    input  lane_pkg::preg_t    src2_i,
    input  lane_pkg::preg_t    dst_i,
    input  logic               ex_writes_i,
    input  logic               wb_writes_i,
    output lane_pkg::byp_sel_t byp1_sel_o,
    output lane_pkg::byp_sel_t byp2_sel_o,
    output logic               ex_valid_o,
    output logic               wb_valid_o,
    output lane_pkg::preg_t    wb_dst_o,
    output logic               rf_wr_en_o
);

    logic            ex_valid_q;
    logic            wb_valid_q;
    lane_pkg::preg_t ex_dst_q;
    lane_pkg::preg_t wb_dst_q;
    logic            ex_fwd;
    logic            wb_fwd;

    // Picks the source of one operand. X wins because it holds the younger result.
    function automatic lane_pkg::byp_sel_t pick_src(input lane_pkg::preg_t src);
        if (ex_fwd && src == ex_dst_q) begin
            return lane_pkg::BYP_EX;
        end else if (wb_fwd && src == wb_dst_q) begin
            return lane_pkg::BYP_WB;
        end
        return lane_pkg::BYP_RF;
    endfunction

    // ----------------------------------------
    // Stage valids and destination tags
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
            ex_dst_q   <= '0;
            wb_dst_q   <= '0;
        end else begin
            ex_valid_q <= issue_valid_i;
            wb_valid_q <= ex_valid_q;
            ex_dst_q   <= dst_i;
            wb_dst_q   <= ex_dst_q;
        end
    end

    // ----------------------------------------
    // Forwarding and writeback
    // ----------------------------------------
    assign ex_fwd = ex_valid_q & ex_writes_i; // A NOP in X offers nothing to forward.
    assign wb_fwd = wb_valid_q & wb_writes_i;

    // The selects follow the stage tags as well as the source tags.
    always_comb begin
        byp1_sel_o = pick_src(src1_i);
        byp2_sel_o = pick_src(src2_i);
    end

    assign ex_valid_o = ex_valid_q;
    assign wb_valid_o = wb_valid_q;
    assign wb_dst_o   = wb_dst_q;
    assign rf_wr_en_o = wb_fwd;

    // A register write must always belong to a completing instruction.
    a_write_has_valid: assert property (
        @(posedge clk) disable iff (rst_i) rf_wr_en_o |-> wb_valid_o
    ) else $error("Register write without a valid W-stage instruction");

endmodule

// File: source/exec_regfile.sv
// Physical register file with two asynchronous read ports and one write port.
// A read in the cycle of a write to the same register returns the old value.
`include "exec_cfg.svh"

module exec_regfile (
    input  logic            clk,
    input  logic            rst_i,
    input  lane_pkg::preg_t rd1_addr_i,
    input  lane_pkg::preg_t rd2_addr_i,
    output isa_pkg::data_t  rd1_data_o,
    output isa_pkg::data_t  rd2_data_o,
    input  logic            wr_en_i,
    input  lane_pkg::preg_t wr_addr_i,
    input  isa_pkg::data_t  wr_data_i
);

    isa_pkg::data_t regs [`NUM_PHYS_REGS];

    // Read ports.
    assign rd1_data_o = regs[rd1_addr_i];
    assign rd2_data_o = regs[rd2_addr_i];

    // Write port. Every register starts at zero after reset.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: source/isa_pkg.sv
// Instruction-level types, opcode encodings and flag bit positions.
// Encodings are local to this lane and are not the MIPS instruction fields.
`include "exec_cfg.svh"

package isa_pkg;

    typedef logic [`SIZE_DATA-1:0]       data_t;
    typedef logic [`SIZE_IMMEDIATE-1:0]  immd_t;
    typedef logic [`SIZE_OPCODE_I-1:0]   opcode_t;
    typedef logic [`EXECUTION_FLAGS-1:0] flags_t;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    localparam opcode_t NOP   = 6'h00;
    localparam opcode_t ADD   = 6'h01;
    localparam opcode_t ADDI  = 6'h02;
    localparam opcode_t ADDU  = 6'h03;
    localparam opcode_t ADDIU = 6'h04;
    localparam opcode_t SUB   = 6'h05;
    localparam opcode_t SUBU  = 6'h06;
    localparam opcode_t MFHI  = 6'h08; // The hi/lo moves are plain pass-throughs.
    localparam opcode_t MTHI  = 6'h09;
    localparam opcode_t MFLO  = 6'h0a;
    localparam opcode_t MTLO  = 6'h0b;
    localparam opcode_t AND_  = 6'h10;
    localparam opcode_t ANDI  = 6'h11;
    localparam opcode_t OR    = 6'h12;
    localparam opcode_t ORI   = 6'h13;
    localparam opcode_t XOR   = 6'h14;
    localparam opcode_t XORI  = 6'h15;
    localparam opcode_t NOR   = 6'h16;
    localparam opcode_t SLL   = 6'h18;
    localparam opcode_t SLLV  = 6'h19;
    localparam opcode_t SRL   = 6'h1a;
    localparam opcode_t SRLV  = 6'h1b;
    localparam opcode_t SRA   = 6'h1c;
    localparam opcode_t SRAV  = 6'h1d;
    localparam opcode_t SLT   = 6'h20;
    localparam opcode_t SLTI  = 6'h21;
    localparam opcode_t SLTU  = 6'h22;
    localparam opcode_t SLTIU = 6'h23;
    localparam opcode_t LUI   = 6'h28;

    // Flag bit positions. Bits 3 and 5 are reserved and read as zero.
    localparam int FLAG_MISPRED  = 0;
    localparam int FLAG_EXCEPT   = 1; // Carry out of the signed add/subtract class.
    localparam int FLAG_EXECUTED = 2;
    localparam int FLAG_WRITES   = 4;

endpackage

// File: source/lane_pkg.sv
// Pipeline types for the execute lane.
// Tags are physical register numbers; there is no renaming inside the lane.
`include "exec_cfg.svh"

package lane_pkg;

    // Physical register tag.
    typedef logic [`SIZE_PHYS_LOG-1:0] preg_t;

    // ----------------------------------------
    // Operand source select
    // ----------------------------------------
    typedef logic [1:0] byp_sel_t;

    // Register file value, no older result in flight.
    localparam byp_sel_t BYP_RF = 2'b00;
    // Combinational ALU output of the X-stage instruction.
    localparam byp_sel_t BYP_EX = 2'b01;
    // Registered result of the W-stage instruction.
    localparam byp_sel_t BYP_WB = 2'b10;

    // Encoding 2'b11 is unused.

endpackage

// File: source/operand_bypass.sv
// Three-way forwarding mux for one source operand.
// The select comes from exec_ctrl; the unused encoding falls back to the register file.

module operand_bypass (
    input  lane_pkg::byp_sel_t sel_i,
    input  isa_pkg::data_t     rf_data_i,
    input  isa_pkg::data_t     ex_data_i,
    input  isa_pkg::data_t     wb_data_i,
    output isa_pkg::data_t     operand_o
);

    // ----------------------------------------
    // Source select
    // ----------------------------------------
    always_comb begin
        case (sel_i)
            lane_pkg::BYP_EX: operand_o = ex_data_i;  // Youngest result, still in the ALU.
            lane_pkg::BYP_WB: operand_o = wb_data_i;  // Result being written this cycle.
            lane_pkg::BYP_RF: operand_o = rf_data_i;
            default:          operand_o = rf_data_i;
        endcase

        // The control never asks for both stages at once.
        assert (sel_i !== 2'b11)
            else $error("Bypass select holds the unused encoding");
    end

endmodule

// File: source/simple_alu.sv
// Purely combinational simple-integer ALU with MIPS-like semantics.
// Shift amounts use five bits, so SIZE_DATA must be 32. No overflow trap is raised.
`include "exec_cfg.svh"

module simple_alu (
    input  isa_pkg::data_t   data1_i,
    input  isa_pkg::data_t   data2_i,
    input  isa_pkg::immd_t   immd_i,
    input  isa_pkg::opcode_t opcode_i,
    output isa_pkg::data_t   result_o,
    output isa_pkg::flags_t  flags_o
);

    localparam int EXT_BITS = `SIZE_DATA - `SIZE_IMMEDIATE;

    isa_pkg::data_t immd_sext;
    isa_pkg::data_t immd_zext;
    logic [4:0]     shamt_imm;
    logic [4:0]     shamt_reg;
    logic           cout;

    // ----------------------------------------
    // Operand preparation
    // ----------------------------------------
    assign immd_sext = {{EXT_BITS{immd_i[`SIZE_IMMEDIATE-1]}}, immd_i};
    assign immd_zext = {{EXT_BITS{1'b0}}, immd_i};
    assign shamt_imm = immd_i[4:0];  // Immediate shifts.
    assign shamt_reg = data1_i[4:0]; // Variable shifts take the amount from source 1.

    // ----------------------------------------
    // Operation select
    // ----------------------------------------
    always_comb begin
        result_o = '0;
        cout     = 1'b0;

        flags_o                         = '0;
        flags_o[isa_pkg::FLAG_MISPRED]  = 1'b0; // No branches here, so never mispredicted.
        flags_o[isa_pkg::FLAG_EXECUTED] = 1'b1;
        flags_o[isa_pkg::FLAG_WRITES]   = 1'b1;

        case (opcode_i)
            // Only the signed class reports its carry.
            isa_pkg::ADD:   {cout, result_o} = data1_i + data2_i;
            isa_pkg::ADDI:  {cout, result_o} = data1_i + immd_sext;
            isa_pkg::SUB:   {cout, result_o} = data1_i - data2_i;
            isa_pkg::SUBU:  result_o = data1_i - data2_i;
            isa_pkg::ADDU:  result_o = data1_i + data2_i;
            isa_pkg::ADDIU: result_o = data1_i + immd_sext;

            isa_pkg::MFHI,
            isa_pkg::MTHI,
            isa_pkg::MFLO,
            isa_pkg::MTLO:  result_o = data1_i; // Source 1 stands in for hi/lo.

            isa_pkg::AND_:  result_o = data1_i & data2_i;
            isa_pkg::ANDI:  result_o = data1_i & immd_zext;
            isa_pkg::OR:    result_o = data1_i | data2_i;
            isa_pkg::ORI:   result_o = data1_i | immd_zext;
            isa_pkg::XOR:   result_o = data1_i ^ data2_i;
            isa_pkg::XORI:  result_o = data1_i ^ immd_zext;
            isa_pkg::NOR:   result_o = ~(data1_i | data2_i);

            isa_pkg::SLL:   result_o = data1_i << shamt_imm;
            isa_pkg::SLLV:  result_o = data2_i << shamt_reg;
            isa_pkg::SRL:   result_o = data1_i >> shamt_imm;
            isa_pkg::SRLV:  result_o = data2_i >> shamt_reg;
            isa_pkg::SRA:   result_o = $signed(data1_i) >>> shamt_imm;
            isa_pkg::SRAV:  result_o = $signed(data2_i) >>> shamt_reg;

            // Compare results live in bit 0, the upper bits stay zero.
            isa_pkg::SLT:   result_o[0] = $signed(data1_i) < $signed(data2_i);
            isa_pkg::SLTI:  result_o[0] = $signed(data1_i) < $signed(immd_sext);
            isa_pkg::SLTU:  result_o[0] = data1_i < data2_i;
            isa_pkg::SLTIU: result_o[0] = data1_i < immd_zext;

            isa_pkg::LUI:   result_o = {immd_i, {EXT_BITS{1'b0}}};

            isa_pkg::NOP: begin
                flags_o[isa_pkg::FLAG_WRITES] = 1'b0;
            end
            default: begin
                // An unknown opcode retires like a NOP.
                flags_o[isa_pkg::FLAG_WRITES] = 1'b0;
            end
        endcase

        flags_o[isa_pkg::FLAG_EXCEPT] = cout;

        // Completion tracking downstream relies on every instruction reporting itself.
        assert (flags_o[isa_pkg::FLAG_EXECUTED] !== 1'b0)
            else $error("ALU produced flags without the executed bit");
    end

endmodule

// File: source/simple_lane_top.sv
// Single-issue simple-ALU execute lane: read and bypass, execute, write back.
// A result leaves two cycles after its issue cycle. No back-pressure is possible.

module simple_lane_top (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             issue_valid_i,
    input  isa_pkg::opcode_t opcode_i,
    input  lane_pkg::preg_t  src1_i,
    input  lane_pkg::preg_t  src2_i,
    input  lane_pkg::preg_t  dst_i,
    input  isa_pkg::immd_t   immd_i,
    output logic             done_valid_o,
    output lane_pkg::preg_t  done_dst_o,
    output isa_pkg::data_t   done_result_o,
    output isa_pkg::flags_t  done_flags_o
);

    lane_pkg::byp_sel_t byp1_sel, byp2_sel;
    logic               ex_valid, wb_valid, rf_wr_en;
    lane_pkg::preg_t    wb_dst;
    isa_pkg::data_t     rf_data1, rf_data2;
    isa_pkg::data_t     opnd1, opnd2;
    isa_pkg::data_t     alu_result;
    isa_pkg::flags_t    alu_flags;

    isa_pkg::opcode_t   x_opcode_q;
    isa_pkg::immd_t     x_immd_q;
    isa_pkg::data_t     x_data1_q, x_data2_q;
    isa_pkg::data_t     w_result_q;
    isa_pkg::flags_t    w_flags_q;

    exec_ctrl u_ctrl (
        .clk, .rst_i, .issue_valid_i, .src1_i, .src2_i, .dst_i,
        .ex_writes_i(alu_flags[isa_pkg::FLAG_WRITES]),
        .wb_writes_i(w_flags_q[isa_pkg::FLAG_WRITES]),
        .byp1_sel_o(byp1_sel), .byp2_sel_o(byp2_sel),
        .ex_valid_o(ex_valid), .wb_valid_o(wb_valid),
        .wb_dst_o(wb_dst), .rf_wr_en_o(rf_wr_en)
    );

    // ----------------------------------------
    // R stage
    // ----------------------------------------
    exec_regfile u_regfile (
        .clk, .rst_i,
        .rd1_addr_i(src1_i), .rd2_addr_i(src2_i),
        .rd1_data_o(rf_data1), .rd2_data_o(rf_data2),
        .wr_en_i(rf_wr_en), .wr_addr_i(wb_dst), .wr_data_i(w_result_q)
    );

    operand_bypass u_byp1 (.sel_i(byp1_sel), .rf_data_i(rf_data1),
        .ex_data_i(alu_result), .wb_data_i(w_result_q), .operand_o(opnd1));
    operand_bypass u_byp2 (.sel_i(byp2_sel), .rf_data_i(rf_data2),
        .ex_data_i(alu_result), .wb_data_i(w_result_q), .operand_o(opnd2));

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            x_opcode_q <= opcode_i;
            x_immd_q   <= immd_i;
            x_data1_q  <= opnd1;
            x_data2_q  <= opnd2;
        end
    end

    // ----------------------------------------
    // X stage
    // ----------------------------------------
    simple_alu u_alu (.data1_i(x_data1_q), .data2_i(x_data2_q), .immd_i(x_immd_q),
        .opcode_i(x_opcode_q), .result_o(alu_result), .flags_o(alu_flags));

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            w_result_q <= alu_result;
            w_flags_q  <= alu_flags;
        end
    end

    // W stage drives the completion port.
    assign done_valid_o  = wb_valid;
    assign done_dst_o    = wb_dst;
    assign done_result_o = w_result_q;
    assign done_flags_o  = w_flags_q;

endmodule

// File: test/lane_testdata.txt
// Columns: opcode_src1_src2_dst_immediate_result_flags, in hex, one instruction per line.
// Flags 14 is executed and writing, 16 adds the carry, 04 is a NOP. Opcode ff ends the list.
01_2_3_1_0000_00000000_14
// Build constants with LUI then ORI.
28_0_0_1_8000_80000000_14
13_1_0_1_0001_80000001_14
28_0_0_2_7fff_7fff0000_14
13_2_0_2_ffff_7fffffff_14
28_0_0_3_ffff_ffff0000_14
13_3_0_3_fff0_fffffff0_14
02_0_0_4_0005_00000005_14
// Add and subtract, carry only for the signed class.
01_2_4_5_0000_80000004_14
01_1_3_6_0000_7ffffff1_16
03_1_3_7_0000_7ffffff1_14
05_4_2_8_0000_80000006_16
06_4_2_9_0000_80000006_14
04_4_0_b_ffff_00000004_14
02_3_0_c_0010_00000000_16
// Logic, shifts and compares.
11_3_0_d_ffff_0000fff0_14
15_1_0_e_8000_80008001_14
16_1_4_f_0000_7ffffffa_14
12_4_d_6_0000_0000fff5_14
1c_3_0_8_0004_ffffffff_14
1a_1_0_9_003f_00000001_14
18_4_0_a_001c_50000000_14
19_6_4_b_0000_00a00000_14
1d_9_1_c_0000_c0000000_14
1b_8_1_d_0000_00000001_14
20_1_4_e_0000_00000001_14
22_1_4_f_0000_00000000_14
21_4_0_5_ffff_00000000_14
23_4_0_6_ffff_00000001_14
09_2_0_7_0000_7fffffff_14
0a_7_0_8_0000_7fffffff_14
// Dependent chains, then a NOP that must not touch r6.
04_0_0_1_0100_00000100_14
03_1_1_2_0000_00000200_14
03_2_1_3_0000_00000300_14
04_0_0_4_0007_00000007_14
15_0_0_9_0055_00000055_14
06_4_3_5_0000_fffffd07_14
03_5_4_6_0000_fffffd0e_14
00_0_0_6_1234_00000000_04
0a_6_0_7_0000_fffffd0e_14
08_6_0_8_0000_fffffd0e_14
ff_0_0_0_0000_00000000_00

// File: test/simple_lane_tb.sv
// Self-checking testbench for simple_lane_top, one issue per cycle from the testdata file.
// Run from the project root so that test/lane_testdata.txt is found.

module simple_lane_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_LINES    = 256;
    localparam int LINE_BITS    = 76;
    localparam int LATENCY      = 2;  // Cycles from the issue cycle to the done cycle.
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;

    logic             clk;
    logic             rst_i;
    logic             issue_valid_i;
    isa_pkg::opcode_t opcode_i;
    lane_pkg::preg_t  src1_i;
    lane_pkg::preg_t  src2_i;
    lane_pkg::preg_t  dst_i;
    isa_pkg::immd_t   immd_i;
    logic             done_valid_o;
    lane_pkg::preg_t  done_dst_o;
    isa_pkg::data_t   done_result_o;
    isa_pkg::flags_t  done_flags_o;

    // Each line holds the opcode in [75:68], src1 in [67:64], src2 in [63:60], dst in [59:56],
    // the immediate in [55:40], the expected result in [39:8] and the expected flags in [7:0].
    logic [LINE_BITS-1:0] vectors [MAX_LINES];

    int pending_q [$];     // Instruction numbers in flight, oldest first.
    int issue_cycle_q [$];
    int cycle        = 0;
    int num_lines    = -1;
    int checked      = 0;
    int value_errors = 0;
    int other_errors = 0;

    simple_lane_top DUT (
        .clk, .rst_i, .issue_valid_i, .opcode_i, .src1_i, .src2_i, .dst_i, .immd_i,
        .done_valid_o, .done_dst_o, .done_result_o, .done_flags_o
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_result(input isa_pkg::data_t got, input isa_pkg::data_t exp,
                                input int num);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0d ns: instruction %0d result %h, expected %h",
                     $time, num, got, exp);
        end
    endtask

    task automatic check_flags(input isa_pkg::flags_t got, input isa_pkg::flags_t exp,
                               input int num);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0d ns: instruction %0d flags %b, expected %b",
                     $time, num, got, exp);
        end
    endtask

    task automatic check_dst(input lane_pkg::preg_t got, input lane_pkg::preg_t exp,
                             input int num);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0d ns: instruction %0d destination %0d, expected %0d",
                     $time, num, got, exp);
        end
    endtask

    task automatic drive_issue(input int idx);
        issue_valid_i = 1'b1;
        opcode_i      = vectors[idx][73:68];
        src1_i        = vectors[idx][67:64];
        src2_i        = vectors[idx][63:60];
        dst_i         = vectors[idx][59:56];
        immd_i        = vectors[idx][55:40];
        pending_q.push_back(idx);
        issue_cycle_q.push_back(cycle);  // The DUT samples this at the coming edge.
    endtask

    task automatic report_and_finish(input bit timed_out);
        $display("Checked %0d of %0d instructions: %0d value errors, %0d other errors",
                 checked, num_lines, value_errors, other_errors);
        if (timed_out || value_errors != 0 || other_errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    endtask

    // ----------------------------------------
    // Completion monitor
    // ----------------------------------------
    always @(negedge clk) begin : completion_monitor
        int idx;
        int issued;
        if (rst_i) begin
            if (done_valid_o !== 1'b0) begin
                other_errors++;
                $display("done_valid_o was high while reset was held, at %0d ns", $time);
            end
        end else if (done_valid_o === 1'b1) begin
            if (pending_q.size() == 0) begin
                other_errors++;
                $display("A completion came at %0d ns with nothing in flight", $time);
            end else begin
                idx    = pending_q.pop_front();
                issued = issue_cycle_q.pop_front();
                if (cycle - issued != LATENCY) begin
                    value_errors++;
                    $display("Fail at %0d ns: instruction %0d took %0d cycles, expected %0d",
                             $time, idx + 1, cycle - issued, LATENCY);
                end
                check_dst(done_dst_o, vectors[idx][59:56], idx + 1);
                check_result(done_result_o, vectors[idx][39:8], idx + 1);
                check_flags(done_flags_o, vectors[idx][5:0], idx + 1);
                checked++;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int idx;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        opcode_i      = '0;
        src1_i        = '0;
        src2_i        = '0;
        dst_i         = '0;
        immd_i        = '0;
        for (int i = 0; i < MAX_LINES; i++) begin
            vectors[i] = '1;  // All ones reads as the end marker.
        end
        $readmemh("test/lane_testdata.txt", vectors);
        idx = 0;
        while (idx < MAX_LINES && vectors[idx][75:68] != 8'hff) begin
            idx++;
        end
        num_lines = idx;
        if (num_lines == 0) begin
            other_errors++;
            $display("No instructions were loaded from the testdata file");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Back-to-back issue, so the data file decides which bypass each line uses.
        for (idx = 0; idx < num_lines; idx++) begin
            drive_issue(idx);
            @(posedge clk);
            #1;
        end
        issue_valid_i = 1'b0;

        while (pending_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // Quiet cycles catch stray completions.
        report_and_finish(1'b0);
    end

    // The watchdog time grows with the number of loaded lines.
    initial begin : watchdog
        wait (num_lines >= 0);
        #((num_lines + 20) * CLK_PERIOD);
        $display("Timeout: the lane stopped completing, %0d instructions never finished",
                 pending_q.size());
        report_and_finish(1'b1);
    end

endmodule
